/* hw/chirp_rx_pkg.sv */
package chirp_rx_pkg;

  localparam int DEF_DATA_WIDTH      = 16;
  localparam int DEF_PHASE_WIDTH     = 24;
  localparam int DEF_SINCOS_WIDTH    = 16;
  localparam int DEF_LUT_ADDR_BITS   = 8;
  localparam int DEF_SCALE_WIDTH     = 18;
  localparam int DEF_SCALE_FRAC_BITS = 14;

  // Chirp shape of the full-size receiver.
  localparam int unsigned DEF_NSIG      = 327680;
  localparam int unsigned DEF_NSYMB     = 64;
  localparam int          DEF_SYNC_BITS = 4;
  localparam logic [DEF_PHASE_WIDTH-1:0] DEF_DPH_INC      = 24'hFE0000;
  localparam logic [DEF_PHASE_WIDTH-1:0] DEF_START_PH     = 24'h000000;
  localparam logic [DEF_PHASE_WIDTH-1:0] DEF_START_PH_INC = 24'h000000;
  localparam logic [DEF_SCALE_WIDTH-1:0] DEF_SCALE        = 18'h03FFF; // Just under unity gain.

  localparam real PI = 3.14159265358979323846;

  // Rounds to the nearest integer, halves away from zero.
  function automatic logic signed [31:0] round_real(input real v);
    if (v >= 0.0) begin
      return $rtoi(v + 0.5);
    end
    return $rtoi(v - 0.5);
  endfunction

  function automatic logic signed [31:0] lut_cos(input int addr, input int addr_bits,
                                                 input int width);
    real angle;
    real amp;
    angle = 2.0 * PI * real'(addr) / real'(1 << addr_bits);
    amp   = real'((1 << (width - 1)) - 1);
    return round_real($cos(angle) * amp);
  endfunction

  function automatic logic signed [31:0] lut_sin(input int addr, input int addr_bits,
                                                 input int width);
    real angle;
    real amp;
    angle = 2.0 * PI * real'(addr) / real'(1 << addr_bits);
    amp   = real'((1 << (width - 1)) - 1);
    return round_real($sin(angle) * amp);
  endfunction

endpackage

/* hw/iq_stream_if.sv */
`timescale 1ns/1ps

interface iq_stream_if #(
  parameter int DATA_WIDTH  = chirp_rx_pkg::DEF_DATA_WIDTH,
  parameter int PHASE_WIDTH = chirp_rx_pkg::DEF_PHASE_WIDTH
);

  logic                          valid;
  logic                          last;
  logic signed [DATA_WIDTH-1:0]  i;
  logic signed [DATA_WIDTH-1:0]  q;
  logic        [PHASE_WIDTH-1:0] phase; // Phase the sample was tagged with.
  logic                          ready;

  modport source (
    output valid,
    output last,
    output i,
    output q,
    output phase,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  i,
    input  q,
    input  phase,
    output ready
  );

endinterface

/* hw/chirp_phase_gen.sv */
`timescale 1ns/1ps

module chirp_phase_gen #(
  parameter int                     DATA_WIDTH   = 16,
  parameter int                     PHASE_WIDTH  = 24,
  parameter int unsigned            NSIG         = 20,
  parameter int unsigned            NSYMB        = 4,
  parameter logic [PHASE_WIDTH-1:0] DPH_INC      = '0,
  parameter logic [PHASE_WIDTH-1:0] START_PH     = '0,
  parameter logic [PHASE_WIDTH-1:0] START_PH_INC = '0,
  parameter int                     SYNC_BITS    = 2
) (
  input  logic                         clk,
  input  logic                         i_arst_n,
  input  logic                         i_srst,
  input  logic signed [DATA_WIDTH-1:0] i_in_i,
  input  logic signed [DATA_WIDTH-1:0] i_in_q,
  input  logic                         i_in_valid,
  input  logic                         i_in_last,
  output logic                         o_in_ready,
  output logic                         o_sync_ready,
  iq_stream_if.source                  o_stream
);

  localparam int SIG_W  = $clog2(NSIG + 1);
  localparam int SYMB_W = $clog2(NSYMB + 1);

  logic [SIG_W-1:0]       sig_cnt;
  logic [SYMB_W-1:0]      symb_cnt;
  logic [PHASE_WIDTH-1:0] ph_inc;
  logic [PHASE_WIDTH-1:0] phase;
  logic [SYNC_BITS-1:0]   sync_cnt;
  logic                   accept;

  assign o_in_ready   = !o_stream.valid || o_stream.ready;
  assign accept       = i_in_valid && o_in_ready;
  assign o_sync_ready = &sync_cnt;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_stream.valid <= 1'b0;
      sig_cnt        <= SIG_W'(NSIG);
      symb_cnt       <= SYMB_W'(NSYMB);
      ph_inc         <= START_PH_INC;
      phase          <= START_PH;
      sync_cnt       <= '1;
    end else if (i_srst) begin
      o_stream.valid <= 1'b0;
      sig_cnt        <= SIG_W'(NSIG);
      symb_cnt       <= SYMB_W'(NSYMB);
      ph_inc         <= START_PH_INC;
      phase          <= START_PH;
      sync_cnt       <= '1;
    end else begin
      if (accept) begin
        o_stream.valid <= 1'b1;
      end else if (o_stream.ready) begin
        o_stream.valid <= 1'b0;
      end
      if (accept) begin
        if (sig_cnt == SIG_W'(NSIG)) begin // End of symbol, restart the chirp.
          sig_cnt <= SIG_W'(1);
          phase   <= START_PH;
          if (symb_cnt == SYMB_W'(NSYMB)) begin
            symb_cnt <= SYMB_W'(1);
            ph_inc   <= START_PH_INC;
            sync_cnt <= sync_cnt + 1'b1;
          end else begin
            symb_cnt <= symb_cnt + 1'b1;
            ph_inc   <= ph_inc + DPH_INC;
          end
        end else begin
          phase   <= phase + ph_inc;
          sig_cnt <= sig_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_stream.i     <= i_in_i;
      o_stream.q     <= i_in_q;
      o_stream.last  <= i_in_last;
      o_stream.phase <= phase; // Tagged before the counters move on.
    end
  end

  a_sig_cnt_range: assert property (@(posedge clk) disable iff (!i_arst_n)
    (sig_cnt != '0) && (sig_cnt <= SIG_W'(NSIG)));

  a_stall_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_stream.valid && !o_stream.ready && !i_srst |=>
      o_stream.valid && $stable(o_stream.i) && $stable(o_stream.q) &&
      $stable(o_stream.last) && $stable(o_stream.phase));

endmodule

/* hw/freq_shift_mixer.sv */
`timescale 1ns/1ps

module freq_shift_mixer #(
  parameter int DATA_WIDTH    = 16,
  parameter int PHASE_WIDTH   = 24,
  parameter int SINCOS_WIDTH  = 16,
  parameter int LUT_ADDR_BITS = 8
) (
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_srst,
  iq_stream_if.sink   i_stream,
  iq_stream_if.source o_stream
);

  localparam int LUT_SIZE = 1 << LUT_ADDR_BITS;
  localparam int MUL_W    = DATA_WIDTH + SINCOS_WIDTH;

  logic signed [SINCOS_WIDTH-1:0] cos_tab [LUT_SIZE];
  logic signed [SINCOS_WIDTH-1:0] sin_tab [LUT_SIZE];
  logic        [LUT_ADDR_BITS-1:0] lut_addr;

  logic                           s1_valid;
  logic                           s1_last;
  logic signed [DATA_WIDTH-1:0]   s1_i;
  logic signed [DATA_WIDTH-1:0]   s1_q;
  logic signed [SINCOS_WIDTH-1:0] s1_cos;
  logic signed [SINCOS_WIDTH-1:0] s1_sin;
  logic                           s1_load;
  logic                           s2_ready;
  logic                           s2_load;
  logic signed [MUL_W-1:0]        p_ic, p_qs, p_qc, p_is;

  for (genvar k = 0; k < LUT_SIZE; k++) begin : g_lut
    assign cos_tab[k] = SINCOS_WIDTH'(chirp_rx_pkg::lut_cos(k, LUT_ADDR_BITS, SINCOS_WIDTH));
    assign sin_tab[k] = SINCOS_WIDTH'(chirp_rx_pkg::lut_sin(k, LUT_ADDR_BITS, SINCOS_WIDTH));
  end

  assign lut_addr       = i_stream.phase[PHASE_WIDTH-1 -: LUT_ADDR_BITS];
  assign s2_ready       = !o_stream.valid || o_stream.ready;
  assign i_stream.ready = !s1_valid || s2_ready;
  assign s1_load        = i_stream.valid && i_stream.ready;
  assign s2_load        = s1_valid && s2_ready;

  // Rotation by minus the phase.
  assign p_ic = s1_i * s1_cos;
  assign p_qs = s1_q * s1_sin;
  assign p_qc = s1_q * s1_cos;
  assign p_is = s1_i * s1_sin;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s1_valid       <= 1'b0;
      o_stream.valid <= 1'b0;
    end else if (i_srst) begin
      s1_valid       <= 1'b0;
      o_stream.valid <= 1'b0;
    end else begin
      if (s1_load) s1_valid <= 1'b1;
      else if (s2_ready) s1_valid <= 1'b0;
      if (s2_load) o_stream.valid <= 1'b1;
      else if (o_stream.ready) o_stream.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load) begin
      s1_i    <= i_stream.i;
      s1_q    <= i_stream.q;
      s1_last <= i_stream.last;
      s1_cos  <= cos_tab[lut_addr];
      s1_sin  <= sin_tab[lut_addr];
    end
    if (s2_load) begin
      o_stream.i    <= {p_ic[MUL_W-1], p_ic} + {p_qs[MUL_W-1], p_qs};
      o_stream.q    <= {p_qc[MUL_W-1], p_qc} - {p_is[MUL_W-1], p_is};
      o_stream.last <= s1_last;
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (!i_arst_n)
    s1_valid && !s2_ready && !i_srst |=>
      s1_valid && $stable(s1_i) && $stable(s1_q) && $stable(s1_last) &&
      $stable(s1_cos) && $stable(s1_sin));

endmodule

/* hw/scale_round_clip.sv */
`timescale 1ns/1ps

module scale_round_clip #(
  parameter int                     DATA_WIDTH      = 16,
  parameter int                     PROD_WIDTH      = 33,
  parameter int                     SINCOS_WIDTH    = 16,
  parameter int                     SCALE_WIDTH     = 18,
  parameter int                     SCALE_FRAC_BITS = 14,
  parameter logic [SCALE_WIDTH-1:0] SCALE           = 18'h04000
) (
  input  logic                         clk,
  input  logic                         i_arst_n,
  input  logic                         i_srst,
  input  logic                         i_out_ready,
  iq_stream_if.sink                    i_stream,
  output logic signed [DATA_WIDTH-1:0] o_out_i,
  output logic signed [DATA_WIDTH-1:0] o_out_q,
  output logic                         o_out_valid,
  output logic                         o_out_last
);

  localparam int SHIFT = SINCOS_WIDTH - 1 + SCALE_FRAC_BITS;
  localparam int SUM_W = PROD_WIDTH + SCALE_WIDTH + 2; // Room for the rounding carry.
  localparam logic signed [SUM_W-1:0] HALF    = SUM_W'(1) << (SHIFT - 1);
  localparam logic signed [SUM_W-1:0] SAT_MAX = (SUM_W'(1) << (DATA_WIDTH - 1)) - 1'b1;
  localparam logic signed [SUM_W-1:0] SAT_MIN = ~SAT_MAX;

  logic load;

  function automatic logic signed [DATA_WIDTH-1:0] scale_clip(
    input logic signed [PROD_WIDTH-1:0] x
  );
    logic signed [SUM_W-1:0] xs;
    logic signed [SUM_W-1:0] gain;
    logic signed [SUM_W-1:0] acc;
    xs   = SUM_W'(x);
    gain = SUM_W'({1'b0, SCALE});
    acc  = (xs * gain + HALF) >>> SHIFT; // Round half-up.
    if (acc > SAT_MAX) begin
      return SAT_MAX[DATA_WIDTH-1:0];
    end else if (acc < SAT_MIN) begin
      return SAT_MIN[DATA_WIDTH-1:0];
    end
    return acc[DATA_WIDTH-1:0];
  endfunction

  assign i_stream.ready = !o_out_valid || i_out_ready;
  assign load           = i_stream.valid && i_stream.ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_out_valid <= 1'b0;
    end else if (i_srst) begin
      o_out_valid <= 1'b0;
    end else if (load) begin
      o_out_valid <= 1'b1;
    end else if (i_out_ready) begin
      o_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      o_out_i    <= scale_clip(i_stream.i);
      o_out_q    <= scale_clip(i_stream.q);
      o_out_last <= i_stream.last;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_out_valid && !i_out_ready && !i_srst |=>
      o_out_valid && $stable(o_out_i) && $stable(o_out_q) && $stable(o_out_last));

endmodule

/* hw/chirp_rx_top.sv */
`timescale 1ns/1ps

module chirp_rx_top #(
  parameter int                     DATA_WIDTH      = chirp_rx_pkg::DEF_DATA_WIDTH,
  parameter int                     PHASE_WIDTH     = chirp_rx_pkg::DEF_PHASE_WIDTH,
  parameter int                     SINCOS_WIDTH    = chirp_rx_pkg::DEF_SINCOS_WIDTH,
  parameter int                     LUT_ADDR_BITS   = chirp_rx_pkg::DEF_LUT_ADDR_BITS,
  parameter int                     SCALE_WIDTH     = chirp_rx_pkg::DEF_SCALE_WIDTH,
  parameter int                     SCALE_FRAC_BITS = chirp_rx_pkg::DEF_SCALE_FRAC_BITS,
  parameter logic [SCALE_WIDTH-1:0] SCALE           = chirp_rx_pkg::DEF_SCALE,
  parameter int unsigned            NSIG            = chirp_rx_pkg::DEF_NSIG,
  parameter int unsigned            NSYMB           = chirp_rx_pkg::DEF_NSYMB,
  parameter logic [PHASE_WIDTH-1:0] DPH_INC         = chirp_rx_pkg::DEF_DPH_INC,
  parameter logic [PHASE_WIDTH-1:0] START_PH        = chirp_rx_pkg::DEF_START_PH,
  parameter logic [PHASE_WIDTH-1:0] START_PH_INC    = chirp_rx_pkg::DEF_START_PH_INC,
  parameter int                     SYNC_BITS       = chirp_rx_pkg::DEF_SYNC_BITS
) (
  input  logic                         clk,
  input  logic                         i_arst_n,
  input  logic                         i_srst,
  input  logic signed [DATA_WIDTH-1:0] i_in_i,
  input  logic signed [DATA_WIDTH-1:0] i_in_q,
  input  logic                         i_in_valid,
  input  logic                         i_in_last,
  output logic                         o_in_ready,
  output logic signed [DATA_WIDTH-1:0] o_out_i,
  output logic signed [DATA_WIDTH-1:0] o_out_q,
  output logic                         o_out_valid,
  output logic                         o_out_last,
  input  logic                         i_out_ready,
  output logic                         o_sync_ready
);

  localparam int PROD_WIDTH = DATA_WIDTH + SINCOS_WIDTH + 1; // Rotated sum of two products.

  iq_stream_if #(.DATA_WIDTH(DATA_WIDTH), .PHASE_WIDTH(PHASE_WIDTH)) gen_to_mix ();
  iq_stream_if #(.DATA_WIDTH(PROD_WIDTH), .PHASE_WIDTH(PHASE_WIDTH)) mix_to_res ();

  chirp_phase_gen #(
    .DATA_WIDTH(DATA_WIDTH), .PHASE_WIDTH(PHASE_WIDTH), .NSIG(NSIG), .NSYMB(NSYMB),
    .DPH_INC(DPH_INC), .START_PH(START_PH), .START_PH_INC(START_PH_INC),
    .SYNC_BITS(SYNC_BITS)
  ) phase_gen_i (
    .clk(clk), .i_arst_n(i_arst_n), .i_srst(i_srst),
    .i_in_i(i_in_i), .i_in_q(i_in_q), .i_in_valid(i_in_valid), .i_in_last(i_in_last),
    .o_in_ready(o_in_ready), .o_sync_ready(o_sync_ready), .o_stream(gen_to_mix.source)
  );

  freq_shift_mixer #(
    .DATA_WIDTH(DATA_WIDTH), .PHASE_WIDTH(PHASE_WIDTH), .SINCOS_WIDTH(SINCOS_WIDTH),
    .LUT_ADDR_BITS(LUT_ADDR_BITS)
  ) mixer_i (
    .clk(clk), .i_arst_n(i_arst_n), .i_srst(i_srst),
    .i_stream(gen_to_mix.sink), .o_stream(mix_to_res.source)
  );

  scale_round_clip #(
    .DATA_WIDTH(DATA_WIDTH), .PROD_WIDTH(PROD_WIDTH), .SINCOS_WIDTH(SINCOS_WIDTH),
    .SCALE_WIDTH(SCALE_WIDTH), .SCALE_FRAC_BITS(SCALE_FRAC_BITS), .SCALE(SCALE)
  ) result_i (
    .clk(clk), .i_arst_n(i_arst_n), .i_srst(i_srst), .i_out_ready(i_out_ready),
    .i_stream(mix_to_res.sink), .o_out_i(o_out_i), .o_out_q(o_out_q),
    .o_out_valid(o_out_valid), .o_out_last(o_out_last)
  );

endmodule

/* sim/chirp_rx_tb.sv */
`timescale 1ns/1ps

module chirp_rx_tb;

  localparam int DW        = chirp_rx_pkg::DEF_DATA_WIDTH;
  localparam int PW        = chirp_rx_pkg::DEF_PHASE_WIDTH;
  localparam int SCW       = chirp_rx_pkg::DEF_SINCOS_WIDTH;
  localparam int LAB       = chirp_rx_pkg::DEF_LUT_ADDR_BITS;
  localparam int GW        = chirp_rx_pkg::DEF_SCALE_WIDTH;
  localparam int GFRAC     = chirp_rx_pkg::DEF_SCALE_FRAC_BITS;
  localparam int unsigned NSIG  = 20;
  localparam int unsigned NSYMB = 4;
  localparam int SYNC_BITS = 2;
  localparam logic [GW-1:0] GAIN         = 18'h0C000; // Gain of 3.0, clips full-scale input.
  localparam logic [PW-1:0] DPH_INC      = 24'h030000;
  localparam logic [PW-1:0] START_PH     = 24'h100000;
  localparam logic [PW-1:0] START_PH_INC = 24'h040000;
  localparam int SHIFT = SCW - 1 + GFRAC;
  localparam longint SAT_MAX = (longint'(1) << (DW - 1)) - 1;
  localparam longint SAT_MIN = -(longint'(1) << (DW - 1));
  localparam logic signed [DW-1:0] FULL_POS = {1'b0, {(DW-1){1'b1}}};
  localparam logic signed [DW-1:0] FULL_NEG = {1'b1, {(DW-1){1'b0}}};
  localparam int N_BASIC  = 200;
  localparam int N_RANDOM = 300;
  localparam int N_LAST   = 150;
  localparam int N_FULL   = 60;
  localparam int N_SYNC   = 260;
  localparam int N_AFTER  = 100;
  localparam int N_TOTAL  = N_BASIC + N_RANDOM + N_LAST + N_FULL + N_SYNC + N_AFTER;
  localparam longint WATCHDOG_NS = (longint'(N_TOTAL) * 20 + 500) * 100;

  logic                 clk = 1'b0;
  logic                 i_arst_n;
  logic                 i_srst;
  logic signed [DW-1:0] i_in_i;
  logic signed [DW-1:0] i_in_q;
  logic                 i_in_valid;
  logic                 i_in_last;
  logic                 o_in_ready;
  logic signed [DW-1:0] o_out_i;
  logic signed [DW-1:0] o_out_q;
  logic                 o_out_valid;
  logic                 o_out_last;
  logic                 i_out_ready;
  logic                 o_sync_ready;

  logic [15:0]          lfsr;
  int unsigned          m_sig;
  int unsigned          m_symb;
  logic [PW-1:0]        m_inc;
  logic [PW-1:0]        m_phase;
  logic [SYNC_BITS-1:0] m_sync;
  logic signed [DW-1:0] exp_i_q[$];
  logic signed [DW-1:0] exp_q_q[$];
  logic                 exp_last_q[$];
  longint               acc_cyc_q[$];
  longint               cycle = 0;
  int                   n_accepted = 0;
  bit                   sync_due = 1'b0;
  bit                   lat_check = 1'b0;
  int                   err_count = 0;
  int                   pass_count = 0;
  int                   fail_count = 0;
  int                   sat_seen = 0;

  chirp_rx_top #(
    .SCALE(GAIN), .NSIG(NSIG), .NSYMB(NSYMB), .DPH_INC(DPH_INC), .START_PH(START_PH),
    .START_PH_INC(START_PH_INC), .SYNC_BITS(SYNC_BITS)
  ) dut_i (
    .clk(clk), .i_arst_n(i_arst_n), .i_srst(i_srst),
    .i_in_i(i_in_i), .i_in_q(i_in_q), .i_in_valid(i_in_valid), .i_in_last(i_in_last),
    .o_in_ready(o_in_ready), .o_out_i(o_out_i), .o_out_q(o_out_q),
    .o_out_valid(o_out_valid), .o_out_last(o_out_last), .i_out_ready(i_out_ready),
    .o_sync_ready(o_sync_ready)
  );

  always #50 clk = ~clk;

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic signed [DW-1:0] apply_gain(input longint x);
    longint acc;
    acc = (x * longint'(GAIN) + (longint'(1) << (SHIFT - 1))) >>> SHIFT;
    if (acc > SAT_MAX) begin
      acc = SAT_MAX;
    end else if (acc < SAT_MIN) begin
      acc = SAT_MIN;
    end
    return DW'(acc);
  endfunction

  task automatic check_sample(input string name, input logic signed [DW-1:0] expv,
                              input logic signed [DW-1:0] actv);
    if (actv !== expv) begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, expv, actv);
      err_count++;
    end
  endtask

  task automatic check_last(input logic expv, input logic actv);
    if (actv !== expv) begin
      $display("[ERROR] o_out_last expected 0x%h got 0x%h", expv, actv);
      err_count++;
    end
  endtask

  task automatic check_sync(input logic expv, input logic actv);
    if (actv !== expv) begin
      $display("[ERROR] o_sync_ready expected 0x%h got 0x%h", expv, actv);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expv, input logic actv);
    if (actv !== expv) begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, expv, actv);
      err_count++;
    end
  endtask

  task automatic check_latency(input longint expv, input longint actv);
    if (actv != expv) begin
      $display("[ERROR] latency expected 0x%h got 0x%h", expv, actv);
      err_count++;
    end
  endtask

  task automatic model_reset();
    m_sig   = NSIG;
    m_symb  = NSYMB;
    m_inc   = START_PH_INC;
    m_phase = START_PH;
    m_sync  = '1;
    exp_i_q.delete();
    exp_q_q.delete();
    exp_last_q.delete();
    acc_cyc_q.delete();
    sync_due = 1'b0;
  endtask

  task automatic model_accept(input logic signed [DW-1:0] si, input logic signed [DW-1:0] sq,
                              input logic sl);
    logic [LAB-1:0] addr;
    longint         c;
    longint         s;
    addr = m_phase[PW-1 -: LAB];
    c    = longint'(chirp_rx_pkg::lut_cos(int'(addr), LAB, SCW));
    s    = longint'(chirp_rx_pkg::lut_sin(int'(addr), LAB, SCW));
    exp_i_q.push_back(apply_gain(longint'(si) * c + longint'(sq) * s));
    exp_q_q.push_back(apply_gain(longint'(sq) * c - longint'(si) * s));
    exp_last_q.push_back(sl);
    acc_cyc_q.push_back(cycle);
    n_accepted++;
    sync_due = 1'b1;
    if (m_sig == NSIG) begin
      m_sig   = 1;
      m_phase = START_PH;
      if (m_symb == NSYMB) begin
        m_symb = 1;
        m_inc  = START_PH_INC;
        m_sync = m_sync + 1'b1;
      end else begin
        m_symb++;
        m_inc = m_inc + DPH_INC;
      end
    end else begin
      m_phase = m_phase + m_inc;
      m_sig++;
    end
  endtask

  task automatic take_output();
    longint lat;
    if (exp_i_q.size() == 0) begin
      $display("[%0t] An output transfer arrived with no sample expected.", $time);
      err_count++;
    end else begin
      if (longint'(exp_i_q[0]) == SAT_MAX || longint'(exp_i_q[0]) == SAT_MIN) begin
        sat_seen++;
      end
      check_sample("o_out_i", exp_i_q.pop_front(), o_out_i);
      check_sample("o_out_q", exp_q_q.pop_front(), o_out_q);
      check_last(exp_last_q.pop_front(), o_out_last);
      lat = cycle - acc_cyc_q.pop_front();
      if (lat_check) begin
        check_latency(4, lat);
      end
    end
  endtask

  // Samples both handshakes on the edge, before the DUT registers update.
  always @(posedge clk) begin
    cycle++;
    if (!i_arst_n || i_srst) begin
      model_reset();
    end else begin
      if (sync_due) begin
        check_sync(&m_sync, o_sync_ready);
        sync_due = 1'b0;
      end
      if (o_out_valid && i_out_ready) begin
        take_output();
      end
      if (i_in_valid && o_in_ready) begin
        model_accept(i_in_i, i_in_q, i_in_last);
      end
    end
  end

  task automatic drive_sample(input bit full);
    logic [12:0] ri;
    logic [12:0] rq;
    if (full) begin
      i_in_i = rand_bits(1) ? FULL_POS : FULL_NEG;
      i_in_q = rand_bits(1) ? FULL_POS : FULL_NEG;
    end else begin
      ri     = 13'(rand_bits(13));
      rq     = 13'(rand_bits(13));
      i_in_i = DW'($signed(ri));
      i_in_q = DW'($signed(rq));
    end
    i_in_last  = (rand_bits(2) == 0);
    i_in_valid = 1'b1;
  endtask

  task automatic drain(input bit stalls);
    int waited;
    waited = 0;
    while (exp_i_q.size() != 0 && waited < 200) begin
      i_out_ready = stalls ? (rand_bits(2) != 0) : 1'b1;
      @(posedge clk);
      #1;
      waited++;
    end
    i_out_ready = 1'b1;
  endtask

  // Holds each beat until the DUT takes it.
  task automatic feed_stream(input int n, input bit gaps, input bit stalls, input bit full);
    int issued;
    int last_acc;
    int target;
    issued   = 0;
    target   = n_accepted + n;
    last_acc = n_accepted;
    while (n_accepted < target) begin
      if (!i_in_valid || n_accepted != last_acc) begin
        last_acc   = n_accepted;
        i_in_valid = 1'b0;
        if (issued < n && !(gaps && rand_bits(2) == 0)) begin
          drive_sample(full);
          issued++;
        end
      end
      i_out_ready = stalls ? (rand_bits(2) != 0) : 1'b1;
      @(posedge clk);
      #1;
    end
    i_in_valid = 1'b0;
  endtask

  task automatic run_stream(input int n, input bit gaps, input bit stalls, input bit full);
    feed_stream(n, gaps, stalls, full);
    drain(stalls);
  endtask

  task automatic finish_test(input int num, input string name, input int base);
    if (exp_i_q.size() != 0) begin
      $display("[%0t] %0d expected samples never came out.", $time, exp_i_q.size());
      err_count++;
    end
    if (err_count == base) begin
      pass_count++;
      $display("[%0t] test %0d, %s: passed", $time, num, name);
    end else begin
      fail_count++;
      $display("[%0t] test %0d, %s: failed with %0d errors", $time, num, name,
               err_count - base);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("The watchdog expired before the tests completed.");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int base;
    int waited;
    lfsr        = 16'd59231;
    i_arst_n    = 1'b0;
    i_srst      = 1'b0;
    i_in_i      = '0;
    i_in_q      = '0;
    i_in_valid  = 1'b0;
    i_in_last   = 1'b0;
    i_out_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    base = err_count;
    check_flag("o_out_valid", 1'b0, o_out_valid);
    check_flag("o_in_ready", 1'b1, o_in_ready);
    check_sync(1'b1, o_sync_ready);
    finish_test(1, "reset state", base);

    base      = err_count;
    lat_check = 1'b1;
    run_stream(N_BASIC, 1'b0, 1'b0, 1'b0);
    lat_check = 1'b0;
    finish_test(2, "full throughput and latency", base);

    base = err_count;
    run_stream(N_RANDOM, 1'b1, 1'b1, 1'b0);
    finish_test(3, "input gaps and output stalls", base);

    base = err_count;
    run_stream(N_LAST, 1'b1, 1'b0, 1'b0);
    finish_test(4, "last flag", base);

    base     = err_count;
    sat_seen = 0;
    run_stream(N_FULL, 1'b0, 1'b1, 1'b1);
    if (sat_seen == 0) begin
      $display("[%0t] Full-scale input produced no saturated output.", $time);
      err_count++;
    end
    finish_test(5, "saturation", base);

    base = err_count;
    feed_stream(N_SYNC, 1'b1, 1'b1, 1'b0);
    i_out_ready = 1'b0;
    waited      = 0;
    while (!o_out_valid && waited < 10) begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_flag("o_out_valid", 1'b1, o_out_valid);
    i_srst = 1'b1; // Counters are mid-symbol and samples are in flight here.
    @(posedge clk);
    #1;
    i_srst = 1'b0;
    check_flag("o_out_valid", 1'b0, o_out_valid);
    check_flag("o_in_ready", 1'b1, o_in_ready);
    check_sync(1'b1, o_sync_ready);
    run_stream(N_AFTER, 1'b1, 1'b1, 1'b0);
    finish_test(6, "sync level and synchronous reset", base);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
hw/chirp_rx_pkg.sv
hw/iq_stream_if.sv
hw/chirp_phase_gen.sv
hw/freq_shift_mixer.sv
hw/scale_round_clip.sv
hw/chirp_rx_top.sv
sim/chirp_rx_tb.sv

/* Makefile */
# Verilator build and run for the chirp dechirp front end.

VERILATOR ?= verilator
TOP       ?= chirp_rx_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
